// ==== ram_pkg.sv ====
/* Word and address types for the stream buffer storage
   Imported by the RAM, the FIFO control and the output stage */

`default_nettype none

package ram_pkg;

    // Bits per stored word
    localparam int DATA_WIDTH = 8;

    // Number of RAM entries, kept a power of two so pointers wrap for free
    localparam int RAM_DEPTH = 8;

    // Address bits needed for RAM_DEPTH entries
    localparam int RAM_ADDR_WIDTH = $clog2(RAM_DEPTH);

    // One stored word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Word address inside the RAM
    typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;

endpackage

`default_nettype wire

// ==== fifo_pkg.sv ====
/* Pointer type and capacity constants for the FIFO control logic
   Pointers carry one extra wrap bit on top of the RAM address */

`default_nettype none

package fifo_pkg;

    import ram_pkg::*;

    // FIFO pointer, RAM address plus a wrap bit
    // Same address with different wrap bits means full
    // Same address with equal wrap bits means empty
    typedef logic [RAM_ADDR_WIDTH:0] ptr_t;

    // Words the whole buffer can hold
    // RAM entries plus the word parked in the output stage
    localparam int BUFFER_CAPACITY = RAM_DEPTH + 1;

endpackage

`default_nettype wire

// ==== dp_ram.sv ====
/* Simple dual-port RAM with one write port and one registered read port
   Read data updates only on an enabled read and holds in between */

`timescale 1ns/1ps
`default_nettype none

module dp_ram
    import ram_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,

    // Write port
    input  logic      wr_en,
    input  ram_addr_t wr_addr,
    input  data_t     wr_data,

    // Read port
    input  logic      rd_en,
    input  ram_addr_t rd_addr,
    output data_t     rd_data
);

    // Storage array
    data_t mem [RAM_DEPTH];

    // Write on every enabled edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read
    // Old contents are returned if the same address is written in this cycle
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== sync_fifo.sv ====
/* Single-clock FIFO control with wrapping pointers and a one-cycle flush
   Stores words in dp_ram; read data arrives one edge after an issued read */

`timescale 1ns/1ps
`default_nettype none

module sync_fifo
    import ram_pkg::*;
    import fifo_pkg::*;
(
    input  logic  clk,
    input  logic  n_rst,
    input  logic  flush,

    // Write side
    input  logic  wr_en,
    input  data_t wr_data,
    output logic  full,

    // Read side
    input  logic  rd_en,
    output data_t rd_data,
    output logic  empty
);

    // Write and read pointers with wrap bit
    ptr_t wr_ptr;
    ptr_t rd_ptr;

    // Write only when there is room
    logic wr_accept;

    assign wr_accept = wr_en & ~full;

    // Same address, opposite wrap bits
    assign full = (wr_ptr[RAM_ADDR_WIDTH] != rd_ptr[RAM_ADDR_WIDTH]) &&
                  (wr_ptr[RAM_ADDR_WIDTH-1:0] == rd_ptr[RAM_ADDR_WIDTH-1:0]);

    // Pointers fully equal
    assign empty = (wr_ptr == rd_ptr);

    // Write pointer, flush takes priority
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
        end else if (wr_accept) begin
            wr_ptr <= wr_ptr + ptr_t'(1);
        end
    end

    // Read pointer
    // The reader only raises rd_en when not empty
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_ptr <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
        end
    end

    // Storage, addressed without the wrap bit
    dp_ram u_ram (
        .clk     (clk),
        .n_rst   (n_rst),
        .wr_en   (wr_accept),
        .wr_addr (wr_ptr[RAM_ADDR_WIDTH-1:0]),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_ptr[RAM_ADDR_WIDTH-1:0]),
        .rd_data (rd_data)
    );

    // Reader must never pull from an empty FIFO
    a_no_read_when_empty: assert property (@(posedge clk) disable iff (!n_rst)
        rd_en |-> !empty)
        else $error("sync_fifo: read issued while empty");

    // Fill level stays within the RAM after every edge
    a_fill_in_range: assert property (@(posedge clk) disable iff (!n_rst)
        1'b1 |=> ptr_t'(wr_ptr - rd_ptr) <= ptr_t'(RAM_DEPTH))
        else $error("sync_fifo: pointer difference exceeds depth");

endmodule

`default_nettype wire

// ==== fifo_out_stage.sv ====
/* Turns the FIFO's registered-read port into a valid/ready stream output
   Keeps one word in the RAM read register and refills it at full rate */

`timescale 1ns/1ps
`default_nettype none

module fifo_out_stage
    import ram_pkg::*;
(
    input  logic  clk,
    input  logic  n_rst,
    input  logic  flush,

    // FIFO read side
    input  logic  fifo_empty,
    output logic  fifo_rd_en,
    input  data_t fifo_rd_data,

    // Stream output
    output logic  out_valid,
    input  logic  out_ready,
    output data_t out_data
);

    // Held word leaves at this edge
    logic out_take;

    // Read register is free or about to be freed
    logic slot_free;

    assign out_take  = out_valid & out_ready;
    assign slot_free = ~out_valid | out_ready;

    // Refill whenever the FIFO has a word and the slot opens
    assign fifo_rd_en = ~fifo_empty & slot_free;

    // The RAM read register is the output register
    assign out_data = fifo_rd_data;

    // Valid flag tracks whether the read register holds an unread word
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            // Anything in the read register is dropped with the FIFO contents
            out_valid <= 1'b0;
        end else if (fifo_rd_en) begin
            // New word lands in the read register at this edge
            out_valid <= 1'b1;
        end else if (out_take) begin
            out_valid <= 1'b0;
        end
    end

    // A stalled word must not change under the consumer
    // This relies on the RAM holding its read register between reads
    a_stable_when_stalled: assert property (@(posedge clk) disable iff (!n_rst)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("fifo_out_stage: out_data changed while stalled");

endmodule

`default_nettype wire

// ==== stream_buffer.sv ====
/* Stream buffer top: valid/ready input, FIFO storage, valid/ready output
   Holds up to BUFFER_CAPACITY words and empties in one cycle on flush */

`timescale 1ns/1ps
`default_nettype none

module stream_buffer
    import ram_pkg::*;
(
    input  logic  clk,
    input  logic  n_rst,
    input  logic  flush,

    // Input stream
    input  logic  in_valid,
    output logic  in_ready,
    input  data_t in_data,

    // Output stream
    output logic  out_valid,
    input  logic  out_ready,
    output data_t out_data
);

    // FIFO status and read port
    logic  fifo_full;
    logic  fifo_empty;
    logic  fifo_rd_en;
    data_t fifo_rd_data;

    // Ready depends on the FIFO state only
    assign in_ready = ~fifo_full;

    // Storage and pointers
    // The FIFO gates in_valid with full, the same condition as in_ready
    sync_fifo u_fifo (
        .clk     (clk),
        .n_rst   (n_rst),
        .flush   (flush),
        .wr_en   (in_valid),
        .wr_data (in_data),
        .full    (fifo_full),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty)
    );

    // Output handshake on top of the registered read
    fifo_out_stage u_out (
        .clk          (clk),
        .n_rst        (n_rst),
        .flush        (flush),
        .fifo_empty   (fifo_empty),
        .fifo_rd_en   (fifo_rd_en),
        .fifo_rd_data (fifo_rd_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data)
    );

endmodule

`default_nettype wire

// ==== tb_stream_buffer.sv ====
/* Directed testbench for the stream buffer
   Drives both handshakes, checks every output word against a reference queue */

`timescale 1ns/1ps
`default_nettype none

module tb_stream_buffer
    import ram_pkg::*;
    import fifo_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 5;
    localparam int STREAM_WORDS  = 32;
    localparam int RANDOM_CYCLES = 200;
    // Longest drain: a full buffer plus pipeline slack
    localparam int DRAIN_LIMIT   = 2 * BUFFER_CAPACITY + 4;
    // Cycle budget per test, used by the watchdog
    localparam int TOTAL_CYCLES  = RESET_CYCLES + 8
                                 + (3 * BUFFER_CAPACITY + 12)
                                 + (RANDOM_CYCLES + DRAIN_LIMIT)
                                 + (STREAM_WORDS + 20)
                                 + (10 + DRAIN_LIMIT);

    logic  clk;
    logic  n_rst;
    logic  flush;
    logic  in_valid;
    logic  in_ready;
    data_t in_data;
    logic  out_valid;
    logic  out_ready;
    data_t out_data;

    // Accepted words in arrival order
    data_t model_q[$];
    int    in_count;
    int    out_count;

    stream_buffer UUT (
        .clk       (clk),
        .n_rst     (n_rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string sig_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL at %0t: %s expected %0h, got %0h", $time, sig_name, expected, actual);
        abort_run("value mismatch");
    endtask

    // Next rising edge, then the drive point just after it
    task automatic advance_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Handshakes are sampled mid-cycle, where inputs and outputs are settled
    always @(negedge clk) begin
        data_t expected;
        if (n_rst) begin
            if (flush) begin
                // Flush drops stored words and any write in the same cycle
                model_q.delete();
            end else begin
                if (out_valid && out_ready) begin
                    if (model_q.size() == 0) begin
                        abort_run("output word appeared with no word pending");
                    end else begin
                        expected = model_q.pop_front();
                        assert (out_data == expected)
                            else report_mismatch("out_data", expected, out_data);
                        out_count++;
                    end
                end
                if (in_valid && in_ready) begin
                    model_q.push_back(in_data);
                    in_count++;
                end
            end
        end
    end

    // Let the outputs run dry with input idle
    task automatic drain_buffer();
        int n;
        n = 0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        while ((model_q.size() != 0 || out_valid) && n < DRAIN_LIMIT) begin
            advance_cycle();
            n++;
        end
        assert (model_q.size() == 0 && !out_valid)
            else abort_run("buffer did not drain within the cycle limit");
    endtask

    task automatic check_reset_state();
        assert (in_ready == 1'b1) else report_mismatch("in_ready", 1, in_ready);
        assert (out_valid == 1'b0) else report_mismatch("out_valid", 0, out_valid);
    endtask

    // One word through an empty buffer, latency counted in edges
    task automatic check_single_word();
        data_t word;
        int    count0;
        word      = data_t'($urandom);
        count0    = in_count;
        in_data   = word;
        in_valid  = 1'b1;
        out_ready = 1'b1;
        advance_cycle();
        in_valid = 1'b0;
        assert (in_count == count0 + 1) else abort_run("single word was not accepted");
        assert (out_valid == 1'b0) else report_mismatch("out_valid", 0, out_valid);
        advance_cycle();
        assert (out_valid == 1'b1) else report_mismatch("out_valid", 1, out_valid);
        assert (out_data == word) else report_mismatch("out_data", word, out_data);
        advance_cycle();
        assert (out_valid == 1'b0) else report_mismatch("out_valid", 0, out_valid);
        assert (model_q.size() == 0) else abort_run("single word did not leave the buffer");
    endtask

    // Stalled output, fill until in_ready drops, then drain
    task automatic check_fill_and_drain();
        int    count0;
        int    n;
        data_t held;
        count0    = in_count;
        n         = 0;
        out_ready = 1'b0;
        in_valid  = 1'b1;
        in_data   = data_t'($urandom);
        while (in_ready && n < BUFFER_CAPACITY + 4) begin
            advance_cycle();
            n++;
            in_data = data_t'($urandom);
        end
        in_valid = 1'b0;
        assert (!in_ready) else abort_run("in_ready never dropped while the output was stalled");
        assert (in_count - count0 == BUFFER_CAPACITY)
            else report_mismatch("accepted words", BUFFER_CAPACITY, in_count - count0);
        // Head word must hold still under back-pressure
        held = model_q[0];
        repeat (3) begin
            advance_cycle();
            assert (out_valid == 1'b1) else report_mismatch("out_valid", 1, out_valid);
            assert (out_data == held) else report_mismatch("out_data", held, out_data);
        end
        drain_buffer();
    endtask

    // Drain shows that every accepted word came out exactly once
    task automatic check_random_traffic();
        repeat (RANDOM_CYCLES) begin
            in_valid  = 1'($urandom_range(1, 0));
            in_data   = data_t'($urandom);
            out_ready = 1'($urandom_range(1, 0));
            advance_cycle();
        end
        drain_buffer();
    endtask

    // Full rate: after the first output one word leaves per cycle
    task automatic check_streaming_rate();
        int count0;
        int out0;
        int n;
        int first;
        count0    = in_count;
        out0      = out_count;
        n         = 0;
        first     = -1;
        out_ready = 1'b1;
        in_valid  = 1'b1;
        in_data   = data_t'($urandom);
        while (out_count - out0 < STREAM_WORDS && n < STREAM_WORDS + 20) begin
            advance_cycle();
            n++;
            if (in_count - count0 >= STREAM_WORDS) begin
                in_valid = 1'b0;
            end else begin
                in_data = data_t'($urandom);
            end
            if (first < 0 && out_count - out0 >= 1) begin
                first = n;
            end
        end
        assert (out_count - out0 == STREAM_WORDS) else abort_run("stream did not complete");
        assert (n - first == STREAM_WORDS - 1)
            else report_mismatch("stream cycles", STREAM_WORDS - 1, n - first);
    endtask

    // Flush with words stored, then check new words come out alone and in order
    task automatic check_flush();
        int out0;
        out_ready = 1'b0;
        in_valid  = 1'b1;
        repeat (5) begin
            in_data = data_t'($urandom);
            advance_cycle();
        end
        in_valid = 1'b0;
        flush    = 1'b1;
        advance_cycle();
        flush = 1'b0;
        assert (out_valid == 1'b0) else report_mismatch("out_valid", 0, out_valid);
        assert (in_ready == 1'b1) else report_mismatch("in_ready", 1, in_ready);
        out0     = out_count;
        in_valid = 1'b1;
        repeat (3) begin
            in_data = data_t'($urandom);
            advance_cycle();
        end
        drain_buffer();
        assert (out_count - out0 == 3) else report_mismatch("words after flush", 3, out_count - out0);
    endtask

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        abort_run("Timeout: the tests did not finish within the cycle budget");
    end

    initial begin
        void'($urandom(32'ha395));
        n_rst     = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        in_count  = 0;
        out_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        n_rst = 1'b1;

        check_reset_state();
        check_single_word();
        check_fill_and_drain();
        check_random_traffic();
        check_streaming_rate();
        check_flush();

        if (model_q.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run("words left over in the reference queue at the end");
        end
    end

endmodule

`default_nettype wire

// ==== stream_buffer.f ====
ram_pkg.sv
fifo_pkg.sv
dp_ram.sv
sync_fifo.sv
fifo_out_stage.sv
stream_buffer.sv
tb_stream_buffer.sv

// ==== Bender.yml ====
package:
  name: stream_buffer

sources:
  - ram_pkg.sv
  - fifo_pkg.sv
  - dp_ram.sv
  - sync_fifo.sv
  - fifo_out_stage.sv
  - stream_buffer.sv
  - target: simulation
    files:
      - tb_stream_buffer.sv
